// File: badge_soc_pkg.sv
package badge_soc_pkg;

    // --------------------
    // Bus geometry
    // --------------------
    localparam int bus_data_width = 32;
    localparam int bus_sel_width  = 4;
    // Word address, byte offset already stripped
    localparam int bus_addr_width = 14;

    // --------------------
    // Address map
    // --------------------
    // Top two address bits pick the region
    localparam int region_msb = 13;
    localparam int region_lsb = 12;

    localparam logic [region_msb-region_lsb:0] region_sram = 2'd0;
    localparam logic [region_msb-region_lsb:0] region_misc = 2'd1;
    // Codes 2 and 3 are unmapped and answer with err

    // SRAM size in words
    localparam int sram_index_width = 10;
    localparam int sram_depth_words = 1 << sram_index_width;

    // --------------------
    // Misc register block
    // --------------------
    localparam int reg_offset_width = 2;

    localparam logic [reg_offset_width-1:0] reg_leds       = 2'd0;
    localparam logic [reg_offset_width-1:0] reg_buttons    = 2'd1;
    localparam logic [reg_offset_width-1:0] reg_irq_status = 2'd2;
    localparam logic [reg_offset_width-1:0] reg_irq_enable = 2'd3;

    // Status LED and button counts
    localparam int led_count    = 3;
    localparam int button_count = 2;

endpackage

// File: bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                                     clk_24mhz,
    input  logic                                     reset_i,
    // Fetch master, read only
    input  logic                                     m0_cyc_i,
    input  logic                                     m0_stb_i,
    input  logic [badge_soc_pkg::bus_addr_width-1:0] m0_adr_i,
    output logic [badge_soc_pkg::bus_data_width-1:0] m0_dat_o,
    output logic                                     m0_ack_o,
    output logic                                     m0_err_o,
    // Data master
    input  logic                                     m1_cyc_i,
    input  logic                                     m1_stb_i,
    input  logic                                     m1_we_i,
    input  logic [badge_soc_pkg::bus_addr_width-1:0] m1_adr_i,
    input  logic [badge_soc_pkg::bus_data_width-1:0] m1_dat_i,
    input  logic [badge_soc_pkg::bus_sel_width-1:0]  m1_sel_i,
    output logic [badge_soc_pkg::bus_data_width-1:0] m1_dat_o,
    output logic                                     m1_ack_o,
    output logic                                     m1_err_o,
    // Shared bus
    output logic                                     s_cyc_o,
    output logic                                     s_stb_o,
    output logic                                     s_we_o,
    output logic [badge_soc_pkg::bus_addr_width-1:0] s_adr_o,
    output logic [badge_soc_pkg::bus_data_width-1:0] s_dat_o,
    output logic [badge_soc_pkg::bus_sel_width-1:0]  s_sel_o,
    input  logic [badge_soc_pkg::bus_data_width-1:0] s_dat_i,
    input  logic                                     s_ack_i,
    input  logic                                     s_err_i
);

    logic grant_m0;
    logic grant_m1;
    logic last_m1;
    logic m0_req;
    logic m1_req;
    logic bus_idle;
    logic pick_m1;

    assign m0_req   = m0_cyc_i && m0_stb_i;
    assign m1_req   = m1_cyc_i && m1_stb_i;
    assign bus_idle = !grant_m0 && !grant_m1;

    // Data master wins when alone, or when fetch was served last
    assign pick_m1 = m1_req && (!m0_req || !last_m1);

    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            grant_m0 <= 1'b0;
            grant_m1 <= 1'b0;
            last_m1  <= 1'b1;
        end else if (bus_idle) begin
            if (m0_req || m1_req) begin
                grant_m0 <= !pick_m1;
                grant_m1 <= pick_m1;
                last_m1  <= pick_m1;
            end
        end else begin
            // Grant lasts until the owner ends its cycle
            if (grant_m0 && !m0_cyc_i) begin
                grant_m0 <= 1'b0;
            end
            if (grant_m1 && !m1_cyc_i) begin
                grant_m1 <= 1'b0;
            end
        end
    end

    // --------------------
    // Request mux
    // --------------------
    always_comb begin
        s_cyc_o = 1'b0;
        s_stb_o = 1'b0;
        s_we_o  = 1'b0;
        s_adr_o = '0;
        s_dat_o = '0;
        s_sel_o = '0;
        if (grant_m0) begin
            // Fetch never writes and always takes the full word
            s_cyc_o = m0_cyc_i;
            s_stb_o = m0_stb_i;
            s_adr_o = m0_adr_i;
            s_sel_o = '1;
        end else if (grant_m1) begin
            s_cyc_o = m1_cyc_i;
            s_stb_o = m1_stb_i;
            s_we_o  = m1_we_i;
            s_adr_o = m1_adr_i;
            s_dat_o = m1_dat_i;
            s_sel_o = m1_sel_i;
        end
    end

    // Responses only reach the owner of the bus
    assign m0_ack_o = grant_m0 && s_ack_i;
    assign m0_err_o = grant_m0 && s_err_i;
    assign m0_dat_o = grant_m0 ? s_dat_i : '0;
    assign m1_ack_o = grant_m1 && s_ack_i;
    assign m1_err_o = grant_m1 && s_err_i;
    assign m1_dat_o = grant_m1 ? s_dat_i : '0;

    grants_exclusive: assert property (
        @(posedge clk_24mhz) disable iff (reset_i) !(grant_m0 && grant_m1));

    // A peer or decoder answer always lands while someone owns the bus
    response_has_owner: assert property (
        @(posedge clk_24mhz) disable iff (reset_i)
        (s_ack_i || s_err_i) |-> (grant_m0 || grant_m1));

endmodule

// File: bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder (
    input  logic                                     clk_24mhz,
    input  logic                                     reset_i,
    // Shared bus
    input  logic                                     cyc_i,
    input  logic                                     stb_i,
    input  logic [badge_soc_pkg::bus_addr_width-1:0] adr_i,
    output logic [badge_soc_pkg::bus_data_width-1:0] dat_o,
    output logic                                     ack_o,
    output logic                                     err_o,
    // SRAM peer
    output logic                                     sram_stb_o,
    input  logic [badge_soc_pkg::bus_data_width-1:0] sram_dat_i,
    input  logic                                     sram_ack_i,
    // Misc register peer
    output logic                                     misc_stb_o,
    input  logic [badge_soc_pkg::bus_data_width-1:0] misc_dat_i,
    input  logic                                     misc_ack_i
);

    logic [badge_soc_pkg::region_msb-badge_soc_pkg::region_lsb:0] region;
    logic hit_sram;
    logic hit_misc;
    logic unmapped_stb;

    assign region   = adr_i[badge_soc_pkg::region_msb:badge_soc_pkg::region_lsb];
    assign hit_sram = (region == badge_soc_pkg::region_sram);
    assign hit_misc = (region == badge_soc_pkg::region_misc);

    // Strobe steering
    assign sram_stb_o   = cyc_i && stb_i && hit_sram;
    assign misc_stb_o   = cyc_i && stb_i && hit_misc;
    assign unmapped_stb = cyc_i && stb_i && !hit_sram && !hit_misc;

    // Answer from whichever peer the address points at
    always_comb begin
        if (hit_sram) begin
            ack_o = sram_ack_i;
            dat_o = sram_dat_i;
        end else if (hit_misc) begin
            ack_o = misc_ack_i;
            dat_o = misc_dat_i;
        end else begin
            ack_o = 1'b0;
            dat_o = '0;
        end
    end

    // Error pulse for holes in the map, single cycle like a peer ack
    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            err_o <= 1'b0;
        end else begin
            err_o <= unmapped_stb && !err_o;
        end
    end

    peer_strobes_exclusive: assert property (
        @(posedge clk_24mhz) disable iff (reset_i) !(sram_stb_o && misc_stb_o));

endmodule

// File: wb_sram.sv
`timescale 1ns/100ps

module wb_sram #(
    parameter int   depth_words = badge_soc_pkg::sram_depth_words,
    localparam int  index_width = $clog2(depth_words)
) (
    input  logic                                     clk_24mhz,
    input  logic                                     reset_i,
    input  logic                                     stb_i,
    input  logic                                     we_i,
    input  logic [index_width-1:0]                   adr_i,
    input  logic [badge_soc_pkg::bus_data_width-1:0] dat_i,
    input  logic [badge_soc_pkg::bus_sel_width-1:0]  sel_i,
    output logic [badge_soc_pkg::bus_data_width-1:0] dat_o,
    output logic                                     ack_o
);

    logic [badge_soc_pkg::bus_data_width-1:0] mem [depth_words];
    logic write_en;

    // One write per request, skipped in the cycle that carries the ack
    assign write_en = stb_i && we_i && !ack_o;

    // --------------------
    // Storage
    // --------------------
    always_ff @(posedge clk_24mhz) begin
        if (write_en) begin
            for (int b = 0; b < badge_soc_pkg::bus_sel_width; b++) begin
                if (sel_i[b]) begin
                    mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
                end
            end
        end
        // Read port, lands together with the ack
        dat_o <= mem[adr_i];
    end

    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    single_ack: assert property (
        @(posedge clk_24mhz) disable iff (reset_i) ack_o |=> !ack_o);

endmodule

// File: misc_regs.sv
`timescale 1ns/100ps

module misc_regs (
    input  logic                                       clk_24mhz,
    input  logic                                       reset_i,
    input  logic                                       stb_i,
    input  logic                                       we_i,
    input  logic [badge_soc_pkg::reg_offset_width-1:0] adr_i,
    input  logic [badge_soc_pkg::bus_data_width-1:0]   dat_i,
    output logic [badge_soc_pkg::bus_data_width-1:0]   dat_o,
    output logic                                       ack_o,
    input  logic [badge_soc_pkg::button_count-1:0]     buttons_i,
    output logic [badge_soc_pkg::led_count-1:0]        leds_o,
    output logic                                       irq_o
);

    localparam int nb = badge_soc_pkg::button_count;

    logic [nb-1:0] btn_meta;
    logic [nb-1:0] btn_sync;
    logic [nb-1:0] btn_prev;
    logic [nb-1:0] btn_rise;
    logic [nb-1:0] irq_status;
    logic [nb-1:0] irq_enable;
    logic [nb-1:0] status_clr;
    logic          wr_en;
    logic [badge_soc_pkg::bus_data_width-1:0] rd_data;

    assign wr_en = stb_i && we_i && !ack_o;

    // --------------------
    // Button inputs
    // --------------------
    // Two flops against metastability, a third for the edge
    always_ff @(posedge clk_24mhz) begin
        btn_meta <= buttons_i;
        btn_sync <= btn_meta;
        btn_prev <= btn_sync;
    end

    assign btn_rise = btn_sync & ~btn_prev;

    // Write one to clear
    assign status_clr = (wr_en && adr_i == badge_soc_pkg::reg_irq_status) ?
                        dat_i[nb-1:0] : '0;

    always_ff @(posedge clk_24mhz) begin
        if (reset_i) begin
            leds_o     <= '0;
            irq_status <= '0;
            irq_enable <= '0;
            irq_o      <= 1'b0;
            ack_o      <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
            if (wr_en && adr_i == badge_soc_pkg::reg_leds) begin
                leds_o <= dat_i[badge_soc_pkg::led_count-1:0];
            end
            if (wr_en && adr_i == badge_soc_pkg::reg_irq_enable) begin
                irq_enable <= dat_i[nb-1:0];
            end
            // A fresh edge beats a clear in the same cycle
            irq_status <= (irq_status & ~status_clr) | btn_rise;
            irq_o      <= |(irq_status & irq_enable);
        end
    end

    // --------------------
    // Read back
    // --------------------
    always_comb begin
        rd_data = '0;
        case (adr_i)
            badge_soc_pkg::reg_leds:       rd_data[badge_soc_pkg::led_count-1:0] = leds_o;
            badge_soc_pkg::reg_buttons:    rd_data[nb-1:0] = btn_sync;
            badge_soc_pkg::reg_irq_status: rd_data[nb-1:0] = irq_status;
            default:                       rd_data[nb-1:0] = irq_enable;
        endcase
    end

    always_ff @(posedge clk_24mhz) begin
        dat_o <= rd_data;
    end

    // Without a write the source of a raised irq is still latched and enabled
    irq_has_source: assert property (
        @(posedge clk_24mhz) disable iff (reset_i)
        (irq_o && !$past(wr_en)) |-> |(irq_status & irq_enable));

endmodule

// File: badge_soc.sv
`timescale 1ns/100ps

module badge_soc (
    input  logic                                     clk_24mhz,
    input  logic                                     reset_i,
    // Instruction fetch bus
    input  logic                                     ibus_cyc_i,
    input  logic                                     ibus_stb_i,
    input  logic [badge_soc_pkg::bus_addr_width-1:0] ibus_adr_i,
    output logic [badge_soc_pkg::bus_data_width-1:0] ibus_dat_o,
    output logic                                     ibus_ack_o,
    output logic                                     ibus_err_o,
    // Data bus
    input  logic                                     dbus_cyc_i,
    input  logic                                     dbus_stb_i,
    input  logic                                     dbus_we_i,
    input  logic [badge_soc_pkg::bus_addr_width-1:0] dbus_adr_i,
    input  logic [badge_soc_pkg::bus_data_width-1:0] dbus_dat_i,
    input  logic [badge_soc_pkg::bus_sel_width-1:0]  dbus_sel_i,
    output logic [badge_soc_pkg::bus_data_width-1:0] dbus_dat_o,
    output logic                                     dbus_ack_o,
    output logic                                     dbus_err_o,
    // Board I/O
    output logic [badge_soc_pkg::led_count-1:0]      leds_o,
    input  logic [badge_soc_pkg::button_count-1:0]   buttons_i,
    output logic                                     irq_o
);

    // Shared bus after the arbiter
    logic                                     s_cyc;
    logic                                     s_stb;
    logic                                     s_we;
    logic [badge_soc_pkg::bus_addr_width-1:0] s_adr;
    logic [badge_soc_pkg::bus_data_width-1:0] s_wdat;
    logic [badge_soc_pkg::bus_sel_width-1:0]  s_sel;
    logic [badge_soc_pkg::bus_data_width-1:0] s_rdat;
    logic                                     s_ack;
    logic                                     s_err;

    // Peer side of the decoder
    logic                                     sram_stb;
    logic [badge_soc_pkg::bus_data_width-1:0] sram_rdat;
    logic                                     sram_ack;
    logic                                     misc_stb;
    logic [badge_soc_pkg::bus_data_width-1:0] misc_rdat;
    logic                                     misc_ack;

    bus_arbiter arbiter (
        .clk_24mhz (clk_24mhz),
        .reset_i   (reset_i),
        .m0_cyc_i  (ibus_cyc_i),
        .m0_stb_i  (ibus_stb_i),
        .m0_adr_i  (ibus_adr_i),
        .m0_dat_o  (ibus_dat_o),
        .m0_ack_o  (ibus_ack_o),
        .m0_err_o  (ibus_err_o),
        .m1_cyc_i  (dbus_cyc_i),
        .m1_stb_i  (dbus_stb_i),
        .m1_we_i   (dbus_we_i),
        .m1_adr_i  (dbus_adr_i),
        .m1_dat_i  (dbus_dat_i),
        .m1_sel_i  (dbus_sel_i),
        .m1_dat_o  (dbus_dat_o),
        .m1_ack_o  (dbus_ack_o),
        .m1_err_o  (dbus_err_o),
        .s_cyc_o   (s_cyc),
        .s_stb_o   (s_stb),
        .s_we_o    (s_we),
        .s_adr_o   (s_adr),
        .s_dat_o   (s_wdat),
        .s_sel_o   (s_sel),
        .s_dat_i   (s_rdat),
        .s_ack_i   (s_ack),
        .s_err_i   (s_err)
    );

    bus_decoder decoder (
        .clk_24mhz  (clk_24mhz),
        .reset_i    (reset_i),
        .cyc_i      (s_cyc),
        .stb_i      (s_stb),
        .adr_i      (s_adr),
        .dat_o      (s_rdat),
        .ack_o      (s_ack),
        .err_o      (s_err),
        .sram_stb_o (sram_stb),
        .sram_dat_i (sram_rdat),
        .sram_ack_i (sram_ack),
        .misc_stb_o (misc_stb),
        .misc_dat_i (misc_rdat),
        .misc_ack_i (misc_ack)
    );

    // --------------------
    // Peers
    // --------------------
    wb_sram sram (
        .clk_24mhz (clk_24mhz),
        .reset_i   (reset_i),
        .stb_i     (sram_stb),
        .we_i      (s_we),
        .adr_i     (s_adr[badge_soc_pkg::sram_index_width-1:0]),
        .dat_i     (s_wdat),
        .sel_i     (s_sel),
        .dat_o     (sram_rdat),
        .ack_o     (sram_ack)
    );

    misc_regs misc (
        .clk_24mhz (clk_24mhz),
        .reset_i   (reset_i),
        .stb_i     (misc_stb),
        .we_i      (s_we),
        .adr_i     (s_adr[badge_soc_pkg::reg_offset_width-1:0]),
        .dat_i     (s_wdat),
        .dat_o     (misc_rdat),
        .ack_o     (misc_ack),
        .buttons_i (buttons_i),
        .leds_o    (leds_o),
        .irq_o     (irq_o)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk_o
);

    // 4 ns period, low for the first half
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

endmodule

// File: badge_soc_tb.sv
`timescale 1ns/100ps

module badge_soc_tb;

    localparam int bus_timeout = 20;
    localparam int irq_timeout = 20;

    logic                                     clk_24mhz;
    logic                                     reset_i;
    logic                                     ibus_cyc;
    logic                                     ibus_stb;
    logic [badge_soc_pkg::bus_addr_width-1:0] ibus_adr;
    logic [badge_soc_pkg::bus_data_width-1:0] ibus_dat;
    logic                                     ibus_ack;
    logic                                     ibus_err;
    logic                                     dbus_cyc;
    logic                                     dbus_stb;
    logic                                     dbus_we;
    logic [badge_soc_pkg::bus_addr_width-1:0] dbus_adr;
    logic [badge_soc_pkg::bus_data_width-1:0] dbus_wdat;
    logic [badge_soc_pkg::bus_sel_width-1:0]  dbus_sel;
    logic [badge_soc_pkg::bus_data_width-1:0] dbus_rdat;
    logic                                     dbus_ack;
    logic                                     dbus_err;
    logic [badge_soc_pkg::led_count-1:0]      leds;
    logic [badge_soc_pkg::button_count-1:0]   buttons;
    logic                                     irq;

    int seed = 32'hedc3;
    int errors = 0;
    int checks = 0;
    int ibus_acks = 0;
    int dbus_acks = 0;
    logic dbus_acked_last = 1'b0;

    tb_clock_gen clock_gen (
        .clk_o (clk_24mhz)
    );

    badge_soc uut (
        .clk_24mhz  (clk_24mhz),
        .reset_i    (reset_i),
        .ibus_cyc_i (ibus_cyc),
        .ibus_stb_i (ibus_stb),
        .ibus_adr_i (ibus_adr),
        .ibus_dat_o (ibus_dat),
        .ibus_ack_o (ibus_ack),
        .ibus_err_o (ibus_err),
        .dbus_cyc_i (dbus_cyc),
        .dbus_stb_i (dbus_stb),
        .dbus_we_i  (dbus_we),
        .dbus_adr_i (dbus_adr),
        .dbus_dat_i (dbus_wdat),
        .dbus_sel_i (dbus_sel),
        .dbus_dat_o (dbus_rdat),
        .dbus_ack_o (dbus_ack),
        .dbus_err_o (dbus_err),
        .leds_o     (leds),
        .buttons_i  (buttons),
        .irq_o      (irq)
    );

    // Ack pulses per master and which master was answered last
    always @(negedge clk_24mhz) begin
        if (ibus_ack) begin
            ibus_acks++;
            dbus_acked_last = 1'b0;
        end
        if (dbus_ack) begin
            dbus_acks++;
            dbus_acked_last = 1'b1;
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    function automatic logic [badge_soc_pkg::bus_addr_width-1:0] misc_addr(
        input logic [badge_soc_pkg::reg_offset_width-1:0] offset
    );
        misc_addr = '0;
        misc_addr[badge_soc_pkg::region_msb:badge_soc_pkg::region_lsb] =
            badge_soc_pkg::region_misc;
        misc_addr[badge_soc_pkg::reg_offset_width-1:0] = offset;
    endfunction

    // --------------------
    // Bus tasks
    // --------------------
    // Both start at a falling edge and end one idle cycle after the answer
    task automatic fetch_read(
        input  logic [badge_soc_pkg::bus_addr_width-1:0] adr,
        output logic [badge_soc_pkg::bus_data_width-1:0] data,
        output logic                                     bus_err
    );
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        data = '0;
        bus_err = 1'b0;
        ibus_adr = adr;
        ibus_cyc = 1'b1;
        ibus_stb = 1'b1;
        while (!done && cycles < bus_timeout) begin
            @(negedge clk_24mhz);
            cycles++;
            if (ibus_ack || ibus_err) begin
                data = ibus_dat;
                bus_err = ibus_err;
                done = 1'b1;
            end
        end
        ibus_cyc = 1'b0;
        ibus_stb = 1'b0;
        if (!done) begin
            errors++;
            $display("Fetch read of address %h got no answer in %0d cycles", adr, bus_timeout);
        end
        @(negedge clk_24mhz);
    endtask

    task automatic data_access(
        input  logic                                     we,
        input  logic [badge_soc_pkg::bus_addr_width-1:0] adr,
        input  logic [badge_soc_pkg::bus_data_width-1:0] wdata,
        input  logic [badge_soc_pkg::bus_sel_width-1:0]  sel,
        output logic [badge_soc_pkg::bus_data_width-1:0] rdata,
        output logic                                     bus_err
    );
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        rdata = '0;
        bus_err = 1'b0;
        dbus_we = we;
        dbus_adr = adr;
        dbus_wdat = wdata;
        dbus_sel = sel;
        dbus_cyc = 1'b1;
        dbus_stb = 1'b1;
        while (!done && cycles < bus_timeout) begin
            @(negedge clk_24mhz);
            cycles++;
            if (dbus_ack || dbus_err) begin
                rdata = dbus_rdat;
                bus_err = dbus_err;
                done = 1'b1;
            end
        end
        dbus_cyc = 1'b0;
        dbus_stb = 1'b0;
        dbus_we = 1'b0;
        if (!done) begin
            errors++;
            $display("Data access to address %h got no answer in %0d cycles", adr, bus_timeout);
        end
        @(negedge clk_24mhz);
    endtask

    task automatic write_word(
        input logic [badge_soc_pkg::bus_addr_width-1:0] adr,
        input logic [badge_soc_pkg::bus_data_width-1:0] data,
        input logic [badge_soc_pkg::bus_sel_width-1:0]  sel
    );
        logic [badge_soc_pkg::bus_data_width-1:0] unused_rdata;
        logic                                     err;
        data_access(1'b1, adr, data, sel, unused_rdata, err);
        check_value("dbus_err_o", 32'(err), 32'd0);
    endtask

    task automatic read_word(
        input  logic [badge_soc_pkg::bus_addr_width-1:0] adr,
        output logic [badge_soc_pkg::bus_data_width-1:0] data
    );
        logic err;
        data_access(1'b0, adr, '0, 4'hf, data, err);
        check_value("dbus_err_o", 32'(err), 32'd0);
    endtask

    task automatic wait_irq_level(input logic level);
        int cycles;
        cycles = 0;
        while (irq !== level && cycles < irq_timeout) begin
            @(negedge clk_24mhz);
            cycles++;
        end
        if (irq !== level) begin
            errors++;
            $display("irq_o did not go to %0b within %0d cycles", level, irq_timeout);
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        logic [31:0] rdata;
        check_value("ibus_ack_o", 32'(ibus_ack), 32'd0);
        check_value("ibus_err_o", 32'(ibus_err), 32'd0);
        check_value("dbus_ack_o", 32'(dbus_ack), 32'd0);
        check_value("dbus_err_o", 32'(dbus_err), 32'd0);
        check_value("irq_o", 32'(irq), 32'd0);
        check_value("leds_o", 32'(leds), 32'd0);
        read_word(misc_addr(badge_soc_pkg::reg_irq_enable), rdata);
        check_value("reg_irq_enable", rdata, 32'd0);
    endtask

    task automatic test_sram_bytes();
        logic [13:0] addrs [4];
        logic [31:0] words [4];
        logic [31:0] rdata;
        logic [31:0] patch;
        for (int i = 0; i < 4; i++) begin
            addrs[i] = 14'(i * 37 + 5);
            words[i] = $random(seed);
            write_word(addrs[i], words[i], 4'hf);
        end
        // Partial overwrite of bytes 0 and 2
        patch = $random(seed);
        write_word(addrs[2], patch, 4'b0101);
        words[2] = (words[2] & 32'hff00_ff00) | (patch & 32'h00ff_00ff);
        for (int i = 0; i < 4; i++) begin
            read_word(addrs[i], rdata);
            check_value("dbus_dat_o", rdata, words[i]);
        end
    endtask

    task automatic test_shared_memory();
        logic [31:0] word;
        logic [31:0] rdata;
        logic        err;
        word = $random(seed);
        write_word(14'h0123, word, 4'hf);
        fetch_read(14'h0123, rdata, err);
        check_value("ibus_err_o", 32'(err), 32'd0);
        check_value("ibus_dat_o", rdata, word);
    endtask

    task automatic test_contention();
        logic [13:0] adr_f;
        logic [13:0] adr_d;
        logic [31:0] word_f;
        logic [31:0] word_d;
        logic [31:0] rdata_f;
        logic [31:0] rdata_d;
        logic        err_f;
        logic        err_d;
        int          acks_f;
        int          acks_d;
        for (int rep = 0; rep < 4; rep++) begin
            adr_f = 14'(512 + rep);
            adr_d = 14'(768 + rep);
            word_f = $random(seed);
            word_d = $random(seed);
            write_word(adr_f, word_f, 4'hf);
            write_word(adr_d, word_d, 4'hf);
            // Odd rounds leave fetch as served last, so data wins first
            if (rep % 2 == 1) begin
                fetch_read(adr_f, rdata_f, err_f);
            end
            acks_f = ibus_acks;
            acks_d = dbus_acks;
            fork
                fetch_read(adr_f, rdata_f, err_f);
                data_access(1'b0, adr_d, '0, 4'hf, rdata_d, err_d);
            join
            check_value("ibus_err_o", 32'(err_f), 32'd0);
            check_value("dbus_err_o", 32'(err_d), 32'd0);
            check_value("ibus_dat_o", rdata_f, word_f);
            check_value("dbus_dat_o", rdata_d, word_d);
            check_value("ibus_ack_o count", 32'(ibus_acks - acks_f), 32'd1);
            check_value("dbus_ack_o count", 32'(dbus_acks - acks_d), 32'd1);
            // The master that lost the round is answered last
            check_value("dbus_ack_o last", 32'(dbus_acked_last), 32'(rep % 2 == 0));
        end
    endtask

    task automatic test_unmapped();
        logic [31:0] word;
        logic [31:0] rdata;
        logic        err;
        int          acks_d;
        word = $random(seed);
        write_word(14'h0040, word, 4'hf);
        acks_d = dbus_acks;
        // Regions 2 and 3 with the same low bits as the SRAM word
        data_access(1'b1, 14'h2040, ~word, 4'hf, rdata, err);
        check_value("dbus_err_o", 32'(err), 32'd1);
        data_access(1'b0, 14'h3040, '0, 4'hf, rdata, err);
        check_value("dbus_err_o", 32'(err), 32'd1);
        check_value("dbus_ack_o count", 32'(dbus_acks - acks_d), 32'd0);
        read_word(14'h0040, rdata);
        check_value("dbus_dat_o", rdata, word);
    endtask

    task automatic test_misc_regs();
        logic [31:0] rdata;
        int          polls;
        write_word(misc_addr(badge_soc_pkg::reg_leds), 32'h5, 4'hf);
        check_value("leds_o", 32'(leds), 32'h5);
        read_word(misc_addr(badge_soc_pkg::reg_leds), rdata);
        check_value("reg_leds", rdata, 32'h5);
        // Button 0 enabled
        write_word(misc_addr(badge_soc_pkg::reg_irq_enable), 32'h1, 4'hf);
        buttons = 2'b01;
        wait_irq_level(1'b1);
        read_word(misc_addr(badge_soc_pkg::reg_irq_status), rdata);
        check_value("reg_irq_status", rdata, 32'h1);
        write_word(misc_addr(badge_soc_pkg::reg_irq_status), 32'h1, 4'hf);
        wait_irq_level(1'b0);
        read_word(misc_addr(badge_soc_pkg::reg_irq_status), rdata);
        check_value("reg_irq_status", rdata, 32'h0);
        // Button 1 latches but stays masked
        buttons = 2'b11;
        polls = 0;
        rdata = '0;
        while (rdata[1] !== 1'b1 && polls < 10) begin
            read_word(misc_addr(badge_soc_pkg::reg_irq_status), rdata);
            polls++;
        end
        if (rdata[1] !== 1'b1) begin
            errors++;
            $display("Button 1 never set its status bit");
        end
        check_value("irq_o", 32'(irq), 32'd0);
    endtask

    initial begin
        reset_i = 1'b1;
        ibus_cyc = 1'b0;
        ibus_stb = 1'b0;
        ibus_adr = '0;
        dbus_cyc = 1'b0;
        dbus_stb = 1'b0;
        dbus_we = 1'b0;
        dbus_adr = '0;
        dbus_wdat = '0;
        dbus_sel = '0;
        buttons = '0;
        repeat (5) @(posedge clk_24mhz);
        @(negedge clk_24mhz);
        reset_i = 1'b0;
        @(negedge clk_24mhz);
        test_reset_state();
        test_sram_bytes();
        test_shared_memory();
        test_contention();
        test_unmapped();
        test_misc_regs();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: badge_soc.f
badge_soc_pkg.sv
bus_arbiter.sv
bus_decoder.sv
wb_sram.sv
misc_regs.sv
badge_soc.sv
tb_clock_gen.sv
badge_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps -f badge_soc.f --top-module badge_soc_tb
./obj_dir/Vbadge_soc_tb | tee sim.log
if grep -q "tests failed" sim.log; then
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    exit 1
fi
